// ==== hdl/s64_alu.sv ====
`timescale 1ns/10ps

module s64_alu (
    input  s64_pkg::word_t   a_i,
    input  s64_pkg::word_t   b_i,
    input  s64_pkg::alu_op_e op_i,
    output s64_pkg::word_t   result_o
);
    import s64_pkg::*;

    logic        sub_en;
    word_t       b_eff;
    logic [64:0] sum;
    logic        carry;
    logic        zero;
    logic        overflow;
    logic        lt_signed;

    // Everything but ADD runs the adder as a subtractor.
    assign sub_en    = (op_i != ALU_ADD);
    assign b_eff     = sub_en ? ~b_i : b_i;
    assign sum       = {1'b0, a_i} + {1'b0, b_eff} + {64'd0, sub_en};
    assign carry     = sum[64];
    assign zero      = (sum[63:0] == '0);
    assign overflow  = (a_i[63] == b_eff[63]) && (sum[63] != a_i[63]);
    assign lt_signed = sum[63] ^ overflow;

    always_comb begin
        case (op_i)
            ALU_ADD, ALU_SUB: result_o = sum[63:0];
            ALU_SLL:  result_o = a_i << b_i[5:0];
            ALU_SLT:  result_o = {63'd0, lt_signed};
            ALU_SLTU: result_o = {63'd0, ~carry};
            ALU_SGE:  result_o = {63'd0, ~lt_signed};
            ALU_SGEU: result_o = {63'd0, carry};
            ALU_SEQ:  result_o = {63'd0, zero};
            ALU_SNE:  result_o = {63'd0, ~zero};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> b_i[5:0];
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> b_i[5:0]);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_BIC:  result_o = a_i & ~b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== hdl/s64_flow_unit.sv ====
`timescale 1ns/10ps

module s64_flow_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  s64_pkg::flow_op_e  op_i,
    input  logic [7:0]         offset_i,
    input  s64_pkg::word_t     tos_i,
    output s64_pkg::pkt_addr_t p_o,
    output logic               redirect_o
);
    import s64_pkg::*;

    pkt_addr_t p;
    pkt_addr_t ia;
    pkt_addr_t rz;
    pkt_addr_t rs_top;
    pkt_addr_t target;
    logic      tos_nz;

    assign tos_nz = |tos_i;
    assign target = ia + pkt_addr_t'(offset_i);

    always_comb begin
        case (op_i)
            FLOW_JT:  redirect_o = tos_nz;
            FLOW_JF:  redirect_o = !tos_nz;
            FLOW_JMP, FLOW_CALL, FLOW_RET: redirect_o = 1'b1;
            default:  redirect_o = 1'b0;
        endcase
    end

    s64_spill_stack #(
        .payload_t (pkt_addr_t)
    ) i_return_stack (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (op_i == FLOW_CALL),
        .pop_i   (op_i == FLOW_RET),
        .dat_i   (rz),
        .top_o   (rs_top)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            p  <= RESET_VECTOR;
            ia <= RESET_VECTOR;
            rz <= '0;
        end else begin
            case (op_i)
                FLOW_FETCH: begin
                    ia <= p;
                    p  <= p + 61'd1;
                end
                // p already points past the calling packet.
                FLOW_CALL: begin
                    rz <= p;
                    p  <= target;
                end
                FLOW_RET: begin
                    rz <= rs_top;
                    p  <= rz;
                end
                default: begin
                    if (redirect_o) begin
                        p <= target;
                    end
                end
            endcase
        end
    end

    assign p_o = p;

endmodule

// ==== hdl/s64_operand_unit.sv ====
`timescale 1ns/10ps

module s64_operand_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  s64_pkg::operand_op_e op_i,
    input  s64_pkg::alu_op_e     alu_op_i,
    input  s64_pkg::word_t       lit_i,
    input  s64_pkg::word_t       rd_data_i,
    output s64_pkg::word_t       tos_o,
    output s64_pkg::word_t       nos_o
);
    import s64_pkg::*;

    word_t x;
    word_t y;
    word_t z;
    word_t ds_top;
    word_t alu_result;
    logic  ds_push;
    logic  ds_pop;

    assign ds_push = (op_i == OPND_PUSH_LIT) || (op_i == OPND_DUP);
    assign ds_pop  = (op_i == OPND_STORE_POP) || (op_i == OPND_ALU_POP) ||
                     (op_i == OPND_DROP);

    // ##############################
    // Spill stack and ALU.
    // ##############################

    s64_spill_stack #(
        .payload_t (word_t)
    ) i_data_stack (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (ds_push),
        .pop_i   (ds_pop),
        .dat_i   (x),
        .top_o   (ds_top)
    );

    s64_alu i_alu (
        .a_i      (y),
        .b_i      (z),
        .op_i     (alu_op_i),
        .result_o (alu_result)
    );

    // ##############################
    // Top-of-stack registers.
    // ##############################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            x <= '0;
            y <= '0;
            z <= '0;
        end else begin
            case (op_i)
                OPND_PUSH_LIT: begin
                    x <= y;
                    y <= z;
                    z <= lit_i;
                end
                OPND_DUP: begin
                    x <= y;
                    y <= z;
                end
                OPND_LOAD: begin
                    z <= rd_data_i;
                end
                OPND_ALU_POP: begin
                    x <= ds_top;
                    y <= x;
                    z <= alu_result;
                end
                OPND_DROP: begin
                    x <= ds_top;
                    y <= x;
                    z <= y;
                end
                // Old x survives in z.
                OPND_STORE_POP: begin
                    x <= ds_top;
                    y <= x;
                    z <= x;
                end
                default: begin
                end
            endcase
        end
    end

    assign tos_o = z;
    assign nos_o = y;

endmodule

// ==== hdl/s64_pkg.sv ====
package s64_pkg;

    typedef logic [63:0] word_t;
    typedef logic [60:0] pkt_addr_t;
    typedef logic [7:0]  sel_t;
    typedef logic [3:0]  slot_t;

    // ##############################
    // Opcodes and sub-codes.
    // ##############################

    typedef enum logic [3:0] {
        OPC_NOP    = 4'd0,
        OPC_LIT8   = 4'd1,
        OPC_LIT16  = 4'd2,
        OPC_LIT32  = 4'd3,
        OPC_STORES = 4'd4,
        OPC_LOADS  = 4'd5,
        OPC_INTOPS = 4'd6,
        OPC_JUMPS  = 4'd7,
        OPC_RET    = 4'd8,
        OPC_STKOPS = 4'd9
    } opc_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_SGE  = 4'd5,
        ALU_SGEU = 4'd6,
        ALU_SEQ  = 4'd7,
        ALU_SNE  = 4'd8,
        ALU_XOR  = 4'd9,
        ALU_SRL  = 4'd10,
        ALU_SRA  = 4'd11,
        ALU_OR   = 4'd12,
        ALU_AND  = 4'd13,
        ALU_BIC  = 4'd14
    } alu_op_e;

    localparam logic [3:0] SUB_SDM   = 4'd0;
    localparam logic [3:0] SUB_LDM   = 4'd3;
    localparam logic [3:0] SUB_JT8   = 4'd0;
    localparam logic [3:0] SUB_JF8   = 4'd1;
    localparam logic [3:0] SUB_J8    = 4'd2;
    localparam logic [3:0] SUB_CALL8 = 4'd3;
    localparam logic [3:0] SUB_DROP  = 4'd0;
    localparam logic [3:0] SUB_DUP   = 4'd1;

    // ##############################
    // Unit commands.
    // ##############################

    typedef enum logic [2:0] {
        OPND_HOLD, OPND_PUSH_LIT, OPND_LOAD, OPND_STORE_POP, OPND_ALU_POP, OPND_DROP, OPND_DUP
    } operand_op_e;

    typedef enum logic [2:0] {
        FLOW_HOLD, FLOW_FETCH, FLOW_JT, FLOW_JF, FLOW_JMP, FLOW_CALL, FLOW_RET
    } flow_op_e;

    // Byte address 0xE000_0000_0000_0000.
    localparam pkt_addr_t RESET_VECTOR = 61'h1C00_0000_0000_0000;
    localparam int        STACK_DEPTH  = 4;

endpackage

// ==== hdl/s64_slot_sequencer.sv ====
`timescale 1ns/10ps

module s64_slot_sequencer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  s64_pkg::word_t       dat_i,
    input  s64_pkg::word_t       tos_i,
    input  s64_pkg::word_t       nos_i,
    input  s64_pkg::pkt_addr_t   p_i,
    input  logic                 redirect_i,
    output s64_pkg::operand_op_e operand_op_o,
    output s64_pkg::alu_op_e     alu_op_o,
    output s64_pkg::word_t       lit_o,
    output s64_pkg::flow_op_e    flow_op_o,
    output logic [7:0]           offset_o,
    output s64_pkg::pkt_addr_t   adr_o,
    output logic                 cyc_o,
    output logic                 we_o,
    output logic                 vpa_o,
    output s64_pkg::sel_t        sel_o,
    output s64_pkg::word_t       dat_o,
    output s64_pkg::opc_e        opc_o
);
    import s64_pkg::*;

    slot_t      t;
    word_t      ir;
    word_t      dr;
    word_t      dr_nxt;
    logic       is_fetch;
    logic [3:0] slot_field;
    opc_e       opcode;
    logic [3:0] sub;
    logic       bus_rd;
    logic       bus_wr;

    assign is_fetch = (t == '0) || (t == ir[63:60]);

    always_comb begin
        case (t)
            4'd1:    slot_field = ir[59:56];
            4'd2:    slot_field = ir[55:52];
            4'd3:    slot_field = ir[51:48];
            4'd4:    slot_field = ir[47:44];
            4'd5:    slot_field = ir[43:40];
            4'd6:    slot_field = ir[39:36];
            4'd7:    slot_field = ir[35:32];
            default: slot_field = 4'd0;
        endcase
    end

    assign opcode = opc_e'(slot_field);
    assign opc_o  = is_fetch ? OPC_NOP : opcode;
    assign sub    = dr[3:0];

    // ##############################
    // Slot decode.
    // ##############################

    always_comb begin
        operand_op_o = OPND_HOLD;
        alu_op_o     = alu_op_e'(sub);
        lit_o        = '0;
        flow_op_o    = FLOW_HOLD;
        offset_o     = dr[11:4];
        dr_nxt       = dr;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        if (is_fetch) begin
            flow_op_o = FLOW_FETCH;
        end else begin
            case (opcode)
                OPC_LIT8: begin
                    operand_op_o = OPND_PUSH_LIT;
                    lit_o        = {{56{dr[7]}}, dr[7:0]};
                    dr_nxt       = dr >> 8;
                end
                OPC_LIT16: begin
                    operand_op_o = OPND_PUSH_LIT;
                    lit_o        = {{48{dr[15]}}, dr[15:0]};
                    dr_nxt       = dr >> 16;
                end
                OPC_LIT32: begin
                    operand_op_o = OPND_PUSH_LIT;
                    lit_o        = {{32{dr[31]}}, dr[31:0]};
                    dr_nxt       = dr >> 32;
                end
                OPC_STORES: begin
                    dr_nxt = dr >> 4;
                    if (sub == SUB_SDM) begin
                        operand_op_o = OPND_STORE_POP;
                        bus_wr       = 1'b1;
                    end
                end
                OPC_LOADS: begin
                    dr_nxt = dr >> 4;
                    if (sub == SUB_LDM) begin
                        operand_op_o = OPND_LOAD;
                        bus_rd       = 1'b1;
                    end
                end
                OPC_INTOPS: begin
                    operand_op_o = OPND_ALU_POP;
                    dr_nxt       = dr >> 4;
                end
                OPC_JUMPS: begin
                    dr_nxt = dr >> 4;
                    case (sub)
                        SUB_JT8:   flow_op_o = FLOW_JT;
                        SUB_JF8:   flow_op_o = FLOW_JF;
                        SUB_J8:    flow_op_o = FLOW_JMP;
                        SUB_CALL8: flow_op_o = FLOW_CALL;
                        default:   flow_op_o = FLOW_HOLD;
                    endcase
                    // Relative forms drop the condition and skip the offset.
                    if (flow_op_o != FLOW_HOLD) begin
                        operand_op_o = OPND_DROP;
                        dr_nxt       = dr >> 12;
                    end
                end
                OPC_RET: begin
                    flow_op_o = FLOW_RET;
                end
                OPC_STKOPS: begin
                    dr_nxt = dr >> 4;
                    if (sub == SUB_DROP) begin
                        operand_op_o = OPND_DROP;
                    end else if (sub == SUB_DUP) begin
                        operand_op_o = OPND_DUP;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ##############################
    // Bus cycle.
    // ##############################

    always_comb begin
        adr_o = '0;
        cyc_o = 1'b0;
        we_o  = 1'b0;
        vpa_o = 1'b0;
        sel_o = '0;
        dat_o = '0;
        if (is_fetch) begin
            adr_o = p_i;
            cyc_o = 1'b1;
            vpa_o = 1'b1;
            sel_o = 8'hFF;
        end else if (bus_rd || bus_wr) begin
            adr_o = tos_i[63:3];
            cyc_o = 1'b1;
            we_o  = bus_wr;
            sel_o = 8'hFF;
            dat_o = bus_wr ? nos_i : '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t  <= '0;
            ir <= '0;
        end else if (is_fetch) begin
            t  <= 4'd1;
            ir <= dat_i;
        end else if (redirect_i) begin
            t <= '0;
        end else begin
            t <= t + 4'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_fetch) begin
            dr <= dat_i;
        end else begin
            dr <= dr_nxt;
        end
    end

endmodule

// ==== hdl/s64_spill_stack.sv ====
`timescale 1ns/10ps

module s64_spill_stack #(
    parameter type payload_t = s64_pkg::word_t
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  logic     pop_i,
    input  payload_t dat_i,
    output payload_t top_o
);
    import s64_pkg::*;

    payload_t stk [STACK_DEPTH];

    // Push wins over pop; the bottom entry repeats on pop.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STACK_DEPTH; i++) begin
                stk[i] <= '0;
            end
        end else if (push_i) begin
            stk[0] <= dat_i;
            for (int i = 1; i < STACK_DEPTH; i++) begin
                stk[i] <= stk[i-1];
            end
        end else if (pop_i) begin
            for (int i = 0; i < STACK_DEPTH - 1; i++) begin
                stk[i] <= stk[i+1];
            end
        end
    end

    assign top_o = stk[0];

endmodule

// ==== hdl/s64x7_core.sv ====
`timescale 1ns/10ps

module s64x7_core (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  s64_pkg::word_t     dat_i,
    output s64_pkg::pkt_addr_t adr_o,
    output logic               cyc_o,
    output logic               we_o,
    output logic               vpa_o,
    output s64_pkg::sel_t      sel_o,
    output s64_pkg::word_t     dat_o,
    output s64_pkg::opc_e      opc_o
);
    import s64_pkg::*;

    operand_op_e operand_op;
    alu_op_e     alu_op;
    word_t       lit;
    flow_op_e    flow_op;
    logic [7:0]  offset;
    word_t       tos;
    word_t       nos;
    pkt_addr_t   p;
    logic        redirect;

    s64_slot_sequencer i_slot_sequencer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dat_i        (dat_i),
        .tos_i        (tos),
        .nos_i        (nos),
        .p_i          (p),
        .redirect_i   (redirect),
        .operand_op_o (operand_op),
        .alu_op_o     (alu_op),
        .lit_o        (lit),
        .flow_op_o    (flow_op),
        .offset_o     (offset),
        .adr_o        (adr_o),
        .cyc_o        (cyc_o),
        .we_o         (we_o),
        .vpa_o        (vpa_o),
        .sel_o        (sel_o),
        .dat_o        (dat_o),
        .opc_o        (opc_o)
    );

    s64_operand_unit i_operand_unit (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .op_i      (operand_op),
        .alu_op_i  (alu_op),
        .lit_i     (lit),
        .rd_data_i (dat_i),
        .tos_o     (tos),
        .nos_o     (nos)
    );

    s64_flow_unit i_flow_unit (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .op_i       (flow_op),
        .offset_i   (offset),
        .tos_i      (tos),
        .p_o        (p),
        .redirect_o (redirect)
    );

endmodule

// ==== s64x7_core.f ====
hdl/s64_pkg.sv
hdl/s64_spill_stack.sv
hdl/s64_alu.sv
hdl/s64_operand_unit.sv
hdl/s64_flow_unit.sv
hdl/s64_slot_sequencer.sv
hdl/s64x7_core.sv
tests/tb_clock_gen.sv
tests/s64x7_core_checker.sv
tests/s64x7_core_tb.sv

// ==== tests/s64x7_core_checker.sv ====
`timescale 1ns/10ps

module s64x7_core_checker (
    input logic          clk_i,
    input logic          rst_n_i,
    input logic          cyc_i,
    input logic          we_i,
    input logic          vpa_i,
    input s64_pkg::sel_t sel_i
);
    import s64_pkg::*;

    // Idle bus drives no byte lanes.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !cyc_i |-> (sel_i == '0))
        else $error("sel_o active outside a bus cycle");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) we_i |-> cyc_i)
        else $error("we_o without cyc_o");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) vpa_i |-> !we_i)
        else $error("write during a program fetch");

endmodule

bind s64x7_core s64x7_core_checker i_checker (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc_o),
    .we_i    (we_o),
    .vpa_i   (vpa_o),
    .sel_i   (sel_o)
);

// ==== tests/s64x7_core_tb.sv ====
`timescale 1ns/10ps

module s64x7_core_tb;
    import s64_pkg::*;

    logic      clk;
    logic      rst_n;
    word_t     dat_i;
    pkt_addr_t adr_o;
    logic      cyc_o;
    logic      we_o;
    logic      vpa_o;
    sel_t      sel_o;
    word_t     dat_o;
    opc_e      opc_o;

    word_t     mem [pkt_addr_t];
    word_t     ref_mem [pkt_addr_t];
    pkt_addr_t exp_fetch [$];
    pkt_addr_t exp_st_adr [$];
    word_t     exp_st_dat [$];
    opc_e      exp_opc [$];
    pkt_addr_t wp;
    word_t     rng;
    int        n_pkts;
    int        wr_count;
    int        fetch_idx;
    int        st_idx;
    int        opc_idx;
    logic      model_ready;

    tb_clock_gen i_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    s64x7_core i_s64x7_core (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .dat_i   (dat_i),
        .adr_o   (adr_o),
        .cyc_o   (cyc_o),
        .we_o    (we_o),
        .vpa_o   (vpa_o),
        .sel_o   (sel_o),
        .dat_o   (dat_o),
        .opc_o   (opc_o)
    );

    // ##############################
    // Memory model.
    // ##############################

    always @(adr_o or wr_count) begin
        dat_i = mem.exists(adr_o) ? mem[adr_o] : '0;
    end

    always @(posedge clk) begin
        if (rst_n && cyc_o && we_o) begin
            mem[adr_o] = dat_o;
            wr_count   = wr_count + 1;
        end
    end

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    function automatic word_t make_pkt(input logic [3:0] n, input logic [27:0] slots,
                                       input logic [31:0] ops);
        return {n, slots, ops};
    endfunction

    function automatic void emit(input word_t pkt);
        mem[wp]     = pkt;
        ref_mem[wp] = pkt;
        wp          = wp + 61'd1;
        n_pkts      = n_pkts + 1;
    endfunction

    // Push a byte address, then store nos there.
    function automatic void emit_store(input logic [15:0] addr);
        emit(make_pkt(4'd3, {OPC_LIT16, OPC_STORES, 20'h0}, {12'h0, SUB_SDM, addr}));
    endfunction

    function automatic void build_image();
        logic [15:0] st;
        logic [31:0] opnd;
        wp = RESET_VECTOR;
        st = 16'h1000;
        // Literals of three widths.
        emit(make_pkt(4'd4, {OPC_LIT8, OPC_LIT16, OPC_STORES, 16'h0},
                      {4'h0, SUB_SDM, st, 8'h85}));
        st = st + 16'd8;
        emit(make_pkt(4'd2, {OPC_LIT16, 24'h0}, {16'h0, 16'h8123}));
        emit_store(st);
        st = st + 16'd8;
        emit(make_pkt(4'd2, {OPC_LIT32, 24'h0}, 32'h8765_4321));
        emit_store(st);
        st = st + 16'd8;
        // Every ALU sub-code on random operands.
        for (int k = 0; k < 15; k++) begin
            opnd = 32'(next_rand());
            emit(make_pkt(4'd2, {OPC_LIT32, 24'h0}, opnd));
            // SEQ sees equal operands so that it can store a one.
            if (k != ALU_SEQ) begin
                opnd = 32'(next_rand());
            end
            emit(make_pkt(4'd2, {OPC_LIT32, 24'h0}, opnd));
            emit(make_pkt(4'd4, {OPC_INTOPS, OPC_LIT16, OPC_STORES, 16'h0},
                          {8'h0, SUB_SDM, st, 4'(k)}));
            st = st + 16'd8;
        end
        // Load, dup and drop.
        mem[61'h800]     = next_rand();
        ref_mem[61'h800] = mem[61'h800];
        emit(make_pkt(4'd4, {OPC_LIT16, OPC_LOADS, OPC_STKOPS, 16'h0},
                      {8'h0, SUB_DUP, SUB_LDM, 16'h4000}));
        emit_store(st);
        st = st + 16'd8;
        emit(make_pkt(4'd4, {OPC_LIT8, OPC_LIT8, OPC_STKOPS, 16'h0},
                      {12'h0, SUB_DROP, 8'h07, 8'h05}));
        emit_store(st);
        // Conditional jumps over a one-cycle filler packet.
        for (int c = 0; c < 4; c++) begin
            emit(make_pkt(4'd3, {OPC_JUMPS, 24'h0} >> 4 | {OPC_LIT8, 24'h0},
                          {12'h0, 8'd2, (c < 2) ? SUB_JT8 : SUB_JF8, 8'(c % 2)}));
            emit(64'h1000_0000_0000_0000);
        end
        // Call depth two, then the halt loop.
        emit(make_pkt(4'd2, {OPC_JUMPS, 24'h0}, {20'h0, 8'd2, SUB_CALL8}));
        emit(make_pkt(4'd2, {OPC_JUMPS, 24'h0}, {20'h0, 8'd0, SUB_J8}));
        emit(make_pkt(4'd2, {OPC_JUMPS, 24'h0}, {20'h0, 8'd2, SUB_CALL8}));
        emit(make_pkt(4'd2, {OPC_RET, 24'h0}, 32'h0));
        emit(make_pkt(4'd2, {OPC_RET, 24'h0}, 32'h0));
    endfunction

    // ##############################
    // Reference model.
    // ##############################

    function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[5:0];
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            ALU_SGE:  return word_t'($signed(a) >= $signed(b));
            ALU_SGEU: return word_t'(a >= b);
            ALU_SEQ:  return word_t'(a == b);
            ALU_SNE:  return word_t'(a != b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[5:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[5:0]);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_BIC:  return a & ~b;
            default:  return '0;
        endcase
    endfunction

    function automatic void run_model();
        word_t     x, y, z, pkt, dr, top;
        word_t     ds [4];
        pkt_addr_t rs [4];
        pkt_addr_t p, ia, rz;
        logic [3:0] n, op, sub;
        logic [7:0] off;
        logic      redir, halt, taken;
        int        steps;
        x = '0;
        y = '0;
        z = '0;
        ds = '{default: '0};
        rs = '{default: '0};
        p = RESET_VECTOR;
        rz = '0;
        halt = 1'b0;
        steps = 0;
        while (!halt && steps < 10000) begin
            pkt = ref_mem.exists(p) ? ref_mem[p] : '0;
            exp_fetch.push_back(p);
            exp_opc.push_back(OPC_NOP);
            ia = p;
            p = p + 61'd1;
            dr = pkt;
            n = pkt[63:60];
            redir = 1'b0;
            steps++;
            for (int t = 1; t < n && !redir; t++) begin
                op = pkt[63 - 4*t -: 4];
                exp_opc.push_back(opc_e'(op));
                sub = dr[3:0];
                top = ds[0];
                case (op)
                    OPC_LIT8, OPC_LIT16, OPC_LIT32: begin
                        ds = '{x, ds[0], ds[1], ds[2]};
                        x = y;
                        y = z;
                        if (op == OPC_LIT8) begin
                            z = {{56{dr[7]}}, dr[7:0]};
                            dr = dr >> 8;
                        end else if (op == OPC_LIT16) begin
                            z = {{48{dr[15]}}, dr[15:0]};
                            dr = dr >> 16;
                        end else begin
                            z = {{32{dr[31]}}, dr[31:0]};
                            dr = dr >> 32;
                        end
                    end
                    OPC_STORES: begin
                        dr = dr >> 4;
                        if (sub == SUB_SDM) begin
                            exp_st_adr.push_back(z[63:3]);
                            exp_st_dat.push_back(y);
                            ref_mem[z[63:3]] = y;
                            ds = '{ds[1], ds[2], ds[3], ds[3]};
                            y = x;
                            z = x;
                            x = top;
                        end
                    end
                    OPC_LOADS: begin
                        dr = dr >> 4;
                        if (sub == SUB_LDM) begin
                            z = ref_mem.exists(z[63:3]) ? ref_mem[z[63:3]] : '0;
                        end
                    end
                    OPC_INTOPS, OPC_STKOPS: begin
                        dr = dr >> 4;
                        if (op == OPC_INTOPS) begin
                            z = ref_alu(alu_op_e'(sub), y, z);
                        end
                        if (op == OPC_INTOPS || sub == SUB_DROP) begin
                            if (op == OPC_STKOPS) begin
                                z = y;
                            end
                            ds = '{ds[1], ds[2], ds[3], ds[3]};
                            y = x;
                            x = top;
                        end else if (sub == SUB_DUP) begin
                            ds = '{x, ds[0], ds[1], ds[2]};
                            x = y;
                            y = z;
                        end
                    end
                    OPC_JUMPS: begin
                        if (sub <= SUB_CALL8) begin
                            off = dr[11:4];
                            dr = dr >> 12;
                            taken = (sub == SUB_JT8) ? (z != '0) :
                                    (sub == SUB_JF8) ? (z == '0) : 1'b1;
                            ds = '{ds[1], ds[2], ds[3], ds[3]};
                            z = y;
                            y = x;
                            x = top;
                            if (sub == SUB_CALL8) begin
                                rs = '{rz, rs[0], rs[1], rs[2]};
                                rz = p;
                            end
                            halt = (sub == SUB_J8) && (off == 8'd0);
                            if (taken) begin
                                p = ia + pkt_addr_t'(off);
                                redir = 1'b1;
                            end
                        end else begin
                            dr = dr >> 4;
                        end
                    end
                    OPC_RET: begin
                        p = rz;
                        rz = rs[0];
                        rs = '{rs[1], rs[2], rs[3], rs[3]};
                        redir = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    endfunction

    // ##############################
    // Checks.
    // ##############################

    task automatic fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_fetch(input pkt_addr_t adr);
        if (adr !== exp_fetch[fetch_idx]) begin
            fail($sformatf("fetch %0d at %h, expected %h", fetch_idx, adr,
                           exp_fetch[fetch_idx]));
        end else begin
            fetch_idx++;
        end
    endtask

    task automatic check_store(input pkt_addr_t adr, input word_t dat);
        if (st_idx >= exp_st_adr.size()) begin
            fail($sformatf("unexpected store to %h", adr));
        end else if (adr !== exp_st_adr[st_idx] || dat !== exp_st_dat[st_idx]) begin
            fail($sformatf("store %0d got %h <- %h, expected %h <- %h", st_idx, adr, dat,
                           exp_st_adr[st_idx], exp_st_dat[st_idx]));
        end else begin
            st_idx++;
        end
    endtask

    task automatic check_opcode(input opc_e opc);
        if (opc !== exp_opc[opc_idx]) begin
            fail($sformatf("cycle %0d shows opcode %0d, expected %0d", opc_idx, opc,
                           exp_opc[opc_idx]));
        end else begin
            opc_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && model_ready) begin
            if (opc_idx < exp_opc.size()) begin
                check_opcode(opc_o);
            end
            if (cyc_o && vpa_o && fetch_idx < exp_fetch.size()) begin
                check_fetch(adr_o);
            end
            if (cyc_o && we_o) begin
                check_store(adr_o, dat_o);
            end
        end
    end

    // Watchdog sized by the program length.
    initial begin
        wait (model_ready);
        repeat (n_pkts * 40 + 20) @(posedge clk);
        $display("Timeout: the program did not reach its final fetch in time");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        model_ready = 1'b0;
        rng = 64'd99;
        n_pkts = 0;
        wr_count = 0;
        fetch_idx = 0;
        st_idx = 0;
        opc_idx = 0;
        dat_i = '0;
        build_image();
        run_model();
        wr_count = 1;
        model_ready = 1'b1;
        while (fetch_idx < exp_fetch.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (st_idx == exp_st_adr.size()) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Only %0d of %0d expected stores were seen", st_idx, exp_st_adr.size());
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset held for ten cycles.
    initial begin
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule
